/* hdl/clockDisplayPkg.sv */
`default_nettype none

package clockDisplayPkg;

	//////////////////////////////
	// Screen timing, 640x480 in 800x525
	localparam logic [9:0] hActive    = 10'd640;
	localparam logic [9:0] hTotal     = 10'd800;
	localparam logic [9:0] hSyncStart = 10'd656;
	localparam logic [9:0] hSyncEnd   = 10'd751;

	localparam logic [9:0] vActive    = 10'd480;
	localparam logic [9:0] vTotal     = 10'd525;
	localparam logic [9:0] vSyncStart = 10'd490;
	localparam logic [9:0] vSyncEnd   = 10'd491;

	//////////////////////////////
	// Digit cells
	localparam logic [9:0] digitWidth  = 10'd32;
	localparam logic [9:0] digitHeight = 10'd64;
	localparam logic [9:0] fontScale   = 10'd4;   // 8x16 font blown up 4x

	localparam logic [9:0] dateRowY  = 10'd128;
	localparam logic [9:0] timeRowY  = 10'd256;
	localparam logic [9:0] timerRowY = 10'd384;

	// Left edges, separators sit in the gaps after columns 1 and 3
	localparam logic [9:0] columnX0 = 10'd96;
	localparam logic [9:0] columnX1 = 10'd128;
	localparam logic [9:0] columnX2 = 10'd192;
	localparam logic [9:0] columnX3 = 10'd224;
	localparam logic [9:0] columnX4 = 10'd288;
	localparam logic [9:0] columnX5 = 10'd320;

	//////////////////////////////
	// Other screen elements
	localparam logic [9:0] dividerX0 = 10'd384;
	localparam logic [9:0] dividerX1 = 10'd415;

	localparam logic [9:0] alarmX0 = 10'd448;
	localparam logic [9:0] alarmX1 = 10'd479;
	localparam logic [9:0] alarmY0 = 10'd448;
	localparam logic [9:0] alarmY1 = 10'd479;

	localparam logic [9:0] panelX1 = 10'd479;

	//////////////////////////////
	// Colours, 4 bits per channel
	localparam logic [11:0] colorDigit   = 12'hFFF;
	localparam logic [11:0] colorPanel   = 12'h222;
	localparam logic [11:0] colorOutside = 12'h048;
	localparam logic [11:0] colorDivider = 12'h00F;
	localparam logic [11:0] colorAlarm   = 12'hF00;
	localparam logic [11:0] colorBlank   = 12'h000;

	// Screen region of one pixel
	typedef enum logic [3:0] {
		Blank,
		Outside,
		Panel,
		Digit,
		Colon,
		Slash,
		Divider,
		Alarm
	} regionE;

	// Glyph codes past the ten digits
	localparam logic [3:0] glyphColon = 4'd10;
	localparam logic [3:0] glyphSlash = 4'd11;
	localparam logic [3:0] glyphBlank = 4'd12;

endpackage

`default_nettype wire

/* hdl/vgaTiming.sv */
`timescale 1ns/10ps
`default_nettype none

module vgaTiming (
	input  logic       CLK,
	input  logic       rstN,
	output logic [9:0] hPos,
	output logic [9:0] vPos,
	output logic       active,
	output logic       hSync,
	output logic       vSync
);

	logic lineEnd;
	logic frameEnd;

	assign lineEnd  = (hPos == clockDisplayPkg::hTotal - 10'd1);
	assign frameEnd = (vPos == clockDisplayPkg::vTotal - 10'd1);

	//////////////////////////////
	// Free-running scan counters
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			hPos <= '0;
			vPos <= '0;
		end else if (lineEnd) begin
			hPos <= '0;
			if (frameEnd) begin
				vPos <= '0;
			end else begin
				vPos <= vPos + 10'd1;
			end
		end else begin
			hPos <= hPos + 10'd1;
		end
	end

	//////////////////////////////
	// Sync pulses are low inside the window
	assign hSync = !((hPos >= clockDisplayPkg::hSyncStart) &&
		(hPos <= clockDisplayPkg::hSyncEnd));
	assign vSync = !((vPos >= clockDisplayPkg::vSyncStart) &&
		(vPos <= clockDisplayPkg::vSyncEnd));

	assign active = (hPos < clockDisplayPkg::hActive) &&
		(vPos < clockDisplayPkg::vActive);   // Visible 640x480

	// Line counter wraps before it can reach the total
	hPosInRange: assert property (
		@(posedge CLK) disable iff (!rstN)
		hPos < clockDisplayPkg::hTotal
	) else $error("hPos reached hTotal");

endmodule

`default_nettype wire

/* hdl/layoutDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module layoutDecoder (
	input  logic                    CLK,
	input  logic                    rstN,
	input  logic [9:0]              hPos,
	input  logic [9:0]              vPos,
	input  logic                    active,
	input  logic                    hSync,
	input  logic                    vSync,
	input  logic                    alarm,
	output clockDisplayPkg::regionE region,
	output logic [1:0]              digitRow,
	output logic [2:0]              digitSlot,
	output logic [3:0]              fontRow,
	output logic [2:0]              fontCol,
	output logic                    dHSync,
	output logic                    dVSync,
	output logic                    dActive,
	output logic [9:0]              dX,
	output logic [9:0]              dY
);

	// Inclusive window test
	function automatic logic inSpan(input logic [9:0] pos, input logic [9:0] lo,
		input logic [9:0] hi);
		return (pos >= lo) && (pos <= hi);
	endfunction

	logic                    inDateRow, inTimeRow, inTimerRow;
	logic [5:0]              inCol;
	logic                    inSepA, inSepB;
	logic                    inDivider, inAlarmBox;
	logic [9:0]              rowTop, colLeft;
	logic [9:0]              xOff, yOff;
	logic [1:0]              rowNext;
	logic [2:0]              slotNext;
	clockDisplayPkg::regionE regionNext;

	//////////////////////////////
	// Window compares
	always_comb begin
		inDateRow  = inSpan(vPos, clockDisplayPkg::dateRowY,
			clockDisplayPkg::dateRowY + clockDisplayPkg::digitHeight - 10'd1);
		inTimeRow  = inSpan(vPos, clockDisplayPkg::timeRowY,
			clockDisplayPkg::timeRowY + clockDisplayPkg::digitHeight - 10'd1);
		inTimerRow = inSpan(vPos, clockDisplayPkg::timerRowY,
			clockDisplayPkg::timerRowY + clockDisplayPkg::digitHeight - 10'd1);

		inCol[0] = inSpan(hPos, clockDisplayPkg::columnX0,
			clockDisplayPkg::columnX0 + clockDisplayPkg::digitWidth - 10'd1);
		inCol[1] = inSpan(hPos, clockDisplayPkg::columnX1,
			clockDisplayPkg::columnX1 + clockDisplayPkg::digitWidth - 10'd1);
		inCol[2] = inSpan(hPos, clockDisplayPkg::columnX2,
			clockDisplayPkg::columnX2 + clockDisplayPkg::digitWidth - 10'd1);
		inCol[3] = inSpan(hPos, clockDisplayPkg::columnX3,
			clockDisplayPkg::columnX3 + clockDisplayPkg::digitWidth - 10'd1);
		inCol[4] = inSpan(hPos, clockDisplayPkg::columnX4,
			clockDisplayPkg::columnX4 + clockDisplayPkg::digitWidth - 10'd1);
		inCol[5] = inSpan(hPos, clockDisplayPkg::columnX5,
			clockDisplayPkg::columnX5 + clockDisplayPkg::digitWidth - 10'd1);

		// Gaps between the digit pairs
		inSepA = inSpan(hPos, clockDisplayPkg::columnX1 + clockDisplayPkg::digitWidth,
			clockDisplayPkg::columnX2 - 10'd1);
		inSepB = inSpan(hPos, clockDisplayPkg::columnX3 + clockDisplayPkg::digitWidth,
			clockDisplayPkg::columnX4 - 10'd1);

		inDivider  = inSpan(hPos, clockDisplayPkg::dividerX0, clockDisplayPkg::dividerX1);
		inAlarmBox = alarm &&
			inSpan(hPos, clockDisplayPkg::alarmX0, clockDisplayPkg::alarmX1) &&
			inSpan(vPos, clockDisplayPkg::alarmY0, clockDisplayPkg::alarmY1);
	end

	//////////////////////////////
	// Cell origin and glyph offsets
	always_comb begin
		rowTop  = clockDisplayPkg::dateRowY;
		rowNext = 2'd0;
		if (inTimeRow) begin
			rowTop  = clockDisplayPkg::timeRowY;
			rowNext = 2'd1;
		end else if (inTimerRow) begin
			rowTop  = clockDisplayPkg::timerRowY;
			rowNext = 2'd2;
		end

		colLeft  = clockDisplayPkg::columnX0;
		slotNext = 3'd0;
		if (inCol[1]) begin
			colLeft  = clockDisplayPkg::columnX1;
			slotNext = 3'd1;
		end else if (inCol[2]) begin
			colLeft  = clockDisplayPkg::columnX2;
			slotNext = 3'd2;
		end else if (inCol[3]) begin
			colLeft  = clockDisplayPkg::columnX3;
			slotNext = 3'd3;
		end else if (inCol[4]) begin
			colLeft  = clockDisplayPkg::columnX4;
			slotNext = 3'd4;
		end else if (inCol[5]) begin
			colLeft  = clockDisplayPkg::columnX5;
			slotNext = 3'd5;
		end else if (inSepA) begin
			colLeft = clockDisplayPkg::columnX1 + clockDisplayPkg::digitWidth;
		end else if (inSepB) begin
			colLeft = clockDisplayPkg::columnX3 + clockDisplayPkg::digitWidth;
		end

		xOff = hPos - colLeft;
		yOff = vPos - rowTop;
	end

	//////////////////////////////
	// Region priority
	always_comb begin
		if (!active) begin
			regionNext = clockDisplayPkg::Blank;
		end else if (inAlarmBox) begin
			regionNext = clockDisplayPkg::Alarm;
		end else if (inDivider) begin
			regionNext = clockDisplayPkg::Divider;
		end else if ((inDateRow || inTimeRow || inTimerRow) && (|inCol)) begin
			regionNext = clockDisplayPkg::Digit;
		end else if ((inTimeRow || inTimerRow) && (inSepA || inSepB)) begin
			regionNext = clockDisplayPkg::Colon;
		end else if (inDateRow && (inSepA || inSepB)) begin
			regionNext = clockDisplayPkg::Slash;
		end else if (hPos <= clockDisplayPkg::panelX1) begin
			regionNext = clockDisplayPkg::Panel;
		end else begin
			regionNext = clockDisplayPkg::Outside;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			region  <= clockDisplayPkg::Blank;
			dHSync  <= 1'b1;   // Syncs idle high
			dVSync  <= 1'b1;
			dActive <= 1'b0;
		end else begin
			region  <= regionNext;
			dHSync  <= hSync;
			dVSync  <= vSync;
			dActive <= active;
		end
	end

	always_ff @(posedge CLK) begin
		digitRow  <= rowNext;
		digitSlot <= slotNext;
		fontRow   <= 4'(yOff / clockDisplayPkg::fontScale);
		fontCol   <= 3'(xOff / clockDisplayPkg::fontScale);
		dX        <= hPos;
		dY        <= vPos;
	end

	// Nothing is drawn outside the visible area
	blankWhenIdle: assert property (
		@(posedge CLK) disable iff (!rstN)
		!dActive |-> region == clockDisplayPkg::Blank
	) else $error("region not Blank outside active video");

endmodule

`default_nettype wire

/* hdl/glyphRom.sv */
`timescale 1ns/10ps
`default_nettype none

module glyphRom (
	input  logic [3:0] glyph,
	input  logic [3:0] fontRow,
	input  logic [2:0] fontCol,
	output logic       fontBit
);

	logic [127:0] glyphBits;   // 16 rows of 8, top row in the MSBs
	logic [7:0]   rowBits;

	//////////////////////////////
	// 8x16 font
	always_comb begin
		case (glyph)
			4'd0:                        glyphBits = 128'h00007CC6_C6CEDEF6_E6C6C67C_00000000;
			4'd1:                        glyphBits = 128'h00001838_78181818_1818187E_00000000;
			4'd2:                        glyphBits = 128'h00007CC6_060C1830_60C0C6FE_00000000;
			4'd3:                        glyphBits = 128'h00007CC6_06063C06_0606C67C_00000000;
			4'd4:                        glyphBits = 128'h00000C1C_3C6CCCFE_0C0C0C1E_00000000;
			4'd5:                        glyphBits = 128'h0000FEC0_C0C0FC06_0606C67C_00000000;
			4'd6:                        glyphBits = 128'h00003860_C0C0FCC6_C6C6C67C_00000000;
			4'd7:                        glyphBits = 128'h0000FEC6_06060C18_30303030_00000000;
			4'd8:                        glyphBits = 128'h00007CC6_C6C67CC6_C6C6C67C_00000000;
			4'd9:                        glyphBits = 128'h00007CC6_C6C67E06_06060C78_00000000;
			clockDisplayPkg::glyphColon: glyphBits = 128'h00000000_18180000_00181800_00000000;
			clockDisplayPkg::glyphSlash: glyphBits = 128'h00000000_02060C18_3060C080_00000000;
			default:                     glyphBits = '0;   // Blank and unused codes
		endcase
	end

	assign rowBits = glyphBits[8 * (15 - fontRow) +: 8];
	assign fontBit = rowBits[7 - fontCol];   // Leftmost pixel in bit 7

endmodule

`default_nettype wire

/* hdl/pixelComposer.sv */
`timescale 1ns/10ps
`default_nettype none

module pixelComposer (
	input  logic                    CLK,
	input  logic                    rstN,
	input  clockDisplayPkg::regionE region,
	input  logic [1:0]              digitRow,
	input  logic [2:0]              digitSlot,
	input  logic [3:0]              fontRow,
	input  logic [2:0]              fontCol,
	input  logic                    dHSync,
	input  logic                    dVSync,
	input  logic [9:0]              dX,
	input  logic [9:0]              dY,
	input  logic [7:0]              year,
	input  logic [7:0]              month,
	input  logic [7:0]              day,
	input  logic [7:0]              hours,
	input  logic [7:0]              minutes,
	input  logic [7:0]              seconds,
	input  logic [7:0]              timerHours,
	input  logic [7:0]              timerMinutes,
	input  logic [7:0]              timerSeconds,
	output logic [11:0]             color,
	output logic                    hSyncOut,
	output logic                    vSyncOut,
	output logic [9:0]              pixelX,
	output logic [9:0]              pixelY
);

	logic [7:0]  pairByte;
	logic [3:0]  nibble;
	logic [3:0]  glyph;
	logic        fontBit;
	logic [11:0] colorNext;

	//////////////////////////////
	// BCD pair for this row and slot
	always_comb begin
		case ({digitRow, digitSlot[2:1]})
			4'b00_00: pairByte = year;
			4'b00_01: pairByte = month;
			4'b00_10: pairByte = day;
			4'b01_00: pairByte = hours;
			4'b01_01: pairByte = minutes;
			4'b01_10: pairByte = seconds;
			4'b10_00: pairByte = timerHours;
			4'b10_01: pairByte = timerMinutes;
			4'b10_10: pairByte = timerSeconds;
			default:  pairByte = 8'h00;
		endcase
	end

	assign nibble = digitSlot[0] ? pairByte[3:0] : pairByte[7:4];   // Tens digit on even slots

	always_comb begin
		case (region)
			clockDisplayPkg::Digit: glyph = nibble;
			clockDisplayPkg::Colon: glyph = clockDisplayPkg::glyphColon;
			clockDisplayPkg::Slash: glyph = clockDisplayPkg::glyphSlash;
			default:                glyph = clockDisplayPkg::glyphBlank;
		endcase
	end

	glyphRom i_glyphRom (
		.glyph   (glyph),
		.fontRow (fontRow),
		.fontCol (fontCol),
		.fontBit (fontBit)
	);

	//////////////////////////////
	// Colour per region
	always_comb begin
		case (region)
			clockDisplayPkg::Outside: colorNext = clockDisplayPkg::colorOutside;
			clockDisplayPkg::Panel:   colorNext = clockDisplayPkg::colorPanel;
			clockDisplayPkg::Divider: colorNext = clockDisplayPkg::colorDivider;
			clockDisplayPkg::Alarm:   colorNext = clockDisplayPkg::colorAlarm;
			clockDisplayPkg::Digit,
			clockDisplayPkg::Colon,
			clockDisplayPkg::Slash:   colorNext = fontBit ? clockDisplayPkg::colorDigit
			                                              : clockDisplayPkg::colorPanel;
			default:                  colorNext = clockDisplayPkg::colorBlank;
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			color    <= clockDisplayPkg::colorBlank;
			hSyncOut <= 1'b1;
			vSyncOut <= 1'b1;
		end else begin
			color    <= colorNext;
			hSyncOut <= dHSync;
			vSyncOut <= dVSync;
		end
	end

	// Position tags along with the colour
	always_ff @(posedge CLK) begin
		pixelX <= dX;
		pixelY <= dY;
	end

	// Sync pulse lies in horizontal blanking, so the output must be dark
	darkDuringSync: assert property (
		@(posedge CLK) disable iff (!rstN)
		!hSyncOut |-> color == clockDisplayPkg::colorBlank
	) else $error("colour driven during hSync");

endmodule

`default_nettype wire

/* hdl/clockDisplay.sv */
`timescale 1ns/10ps
`default_nettype none

module clockDisplay (
	input  logic        CLK,
	input  logic        rstN,
	input  logic [7:0]  year,
	input  logic [7:0]  month,
	input  logic [7:0]  day,
	input  logic [7:0]  hours,
	input  logic [7:0]  minutes,
	input  logic [7:0]  seconds,
	input  logic [7:0]  timerHours,
	input  logic [7:0]  timerMinutes,
	input  logic [7:0]  timerSeconds,
	input  logic        alarm,
	output logic [11:0] color,
	output logic        hSyncOut,
	output logic        vSyncOut,
	output logic [9:0]  pixelX,
	output logic [9:0]  pixelY
);

	logic [9:0]              hPos, vPos;
	logic                    active, hSync, vSync;
	clockDisplayPkg::regionE region;
	logic [1:0]              digitRow;
	logic [2:0]              digitSlot;
	logic [3:0]              fontRow;
	logic [2:0]              fontCol;
	logic                    dHSync, dVSync, dActive;
	logic [9:0]              dX, dY;

	//////////////////////////////
	// Scan position
	vgaTiming i_vgaTiming (
		.CLK    (CLK),
		.rstN   (rstN),
		.hPos   (hPos),
		.vPos   (vPos),
		.active (active),
		.hSync  (hSync),
		.vSync  (vSync)
	);

	// Stage 1, region and glyph coordinates
	layoutDecoder i_layoutDecoder (
		.CLK       (CLK),
		.rstN      (rstN),
		.hPos      (hPos),
		.vPos      (vPos),
		.active    (active),
		.hSync     (hSync),
		.vSync     (vSync),
		.alarm     (alarm),
		.region    (region),
		.digitRow  (digitRow),
		.digitSlot (digitSlot),
		.fontRow   (fontRow),
		.fontCol   (fontCol),
		.dHSync    (dHSync),
		.dVSync    (dVSync),
		.dActive   (dActive),
		.dX        (dX),
		.dY        (dY)
	);

	// Stage 2, font lookup and colour
	pixelComposer i_pixelComposer (
		.CLK          (CLK),
		.rstN         (rstN),
		.region       (region),
		.digitRow     (digitRow),
		.digitSlot    (digitSlot),
		.fontRow      (fontRow),
		.fontCol      (fontCol),
		.dHSync       (dHSync),
		.dVSync       (dVSync),
		.dX           (dX),
		.dY           (dY),
		.year         (year),
		.month        (month),
		.day          (day),
		.hours        (hours),
		.minutes      (minutes),
		.seconds      (seconds),
		.timerHours   (timerHours),
		.timerMinutes (timerMinutes),
		.timerSeconds (timerSeconds),
		.color        (color),
		.hSyncOut     (hSyncOut),
		.vSyncOut     (vSyncOut),
		.pixelX       (pixelX),
		.pixelY       (pixelY)
	);

	// Colour is only produced for visible pixels of the previous stage
	activeOrDark: assert property (
		@(posedge CLK) disable iff (!rstN)
		!dActive |=> color == clockDisplayPkg::colorBlank
	) else $error("colour outside active video");

endmodule

`default_nettype wire

/* sim/displayRef.svh */
`ifndef DISPLAY_REF_SVH
`define DISPLAY_REF_SVH

// Digits 0-9, colon, slash, blank; one byte per font row with the top row first
localparam logic [127:0] fontTable [0:12] = '{
	128'h00007CC6_C6CEDEF6_E6C6C67C_00000000,
	128'h00001838_78181818_1818187E_00000000,
	128'h00007CC6_060C1830_60C0C6FE_00000000,
	128'h00007CC6_06063C06_0606C67C_00000000,
	128'h00000C1C_3C6CCCFE_0C0C0C1E_00000000,
	128'h0000FEC0_C0C0FC06_0606C67C_00000000,
	128'h00003860_C0C0FCC6_C6C6C67C_00000000,
	128'h0000FEC6_06060C18_30303030_00000000,
	128'h00007CC6_C6C67CC6_C6C6C67C_00000000,
	128'h00007CC6_C6C67E06_06060C78_00000000,
	128'h00000000_18180000_00181800_00000000,
	128'h00000000_02060C18_3060C080_00000000,
	128'h00000000_00000000_00000000_00000000
};

function automatic logic fontPixel(input int glyph, input int row, input int col);
	logic [127:0] rows;
	rows = fontTable[glyph];
	return rows[127 - 8 * row - col];   // Bit 7 of a byte is the leftmost pixel
endfunction

// Colour the screen should show at (x, y)
function automatic logic [11:0] expectedColor(input int x, input int y,
	input logic [71:0] bcd, input logic alarmOn);
	int row;
	int glyph;
	int cellX;
	int cellY;
	int r;
	int s;
	int g;
	logic [7:0] pair;
	row = -1;
	glyph = -1;
	cellX = 0;
	cellY = 0;
	if (x >= 640 || y >= 480)
		return clockDisplayPkg::colorBlank;
	if (alarmOn && x >= 448 && x <= 479 && y >= 448 && y <= 479)
		return clockDisplayPkg::colorAlarm;
	if (x >= 384 && x <= 415)
		return clockDisplayPkg::colorDivider;
	for (r = 0; r < 3; r++) begin
		if (y >= 128 * (r + 1) && y < 128 * (r + 1) + 64)
			row = r;   // Rows sit at 128, 256, 384
	end
	if (row >= 0) begin
		cellY = y - 128 * (row + 1);
		for (s = 0; s < 6; s++) begin
			// Pairs of 32 wide cells with a 32 wide gap after each pair
			if (x >= 96 + 32 * s + 32 * (s / 2) && x < 128 + 32 * s + 32 * (s / 2)) begin
				pair = bcd[71 - 8 * (3 * row + s / 2) -: 8];
				glyph = (s % 2 == 1) ? int'(pair[3:0]) : int'(pair[7:4]);
				cellX = x - (96 + 32 * s + 32 * (s / 2));
			end
		end
		for (g = 0; g < 2; g++) begin
			if (x >= 160 + 96 * g && x < 192 + 96 * g) begin
				glyph = (row == 0) ? 11 : 10;   // Slash in the date row
				cellX = x - (160 + 96 * g);
			end
		end
	end
	if (glyph >= 0)
		return fontPixel(glyph, cellY / 4, cellX / 4) ? clockDisplayPkg::colorDigit
			: clockDisplayPkg::colorPanel;
	if (x <= 479)
		return clockDisplayPkg::colorPanel;
	return clockDisplayPkg::colorOutside;
endfunction

`endif

/* sim/displayChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module displayChecker (
	input  logic        CLK,
	input  logic        rstN,
	input  logic [7:0]  year, month, day,
	input  logic [7:0]  hours, minutes, seconds,
	input  logic [7:0]  timerHours, timerMinutes, timerSeconds,
	input  logic        alarm,
	input  logic [11:0] color,
	input  logic        hSyncOut,
	input  logic        vSyncOut,
	input  logic [9:0]  pixelX,
	input  logic [9:0]  pixelY,
	output logic [31:0] errorCount,
	output logic [31:0] pixelCount,
	output logic [31:0] frameCount,
	output logic [31:0] redCount
);

	`include "displayRef.svh"

	int          errors = 0;
	int          pixels = 0;
	int          frames = 0;
	int          redPixels = 0;
	int          warmCycles = 0;
	logic        havePrev = 1'b0;
	logic [9:0]  lastX, lastY, wantX, wantY;
	logic [11:0] wantColor;
	logic        wantH, wantV;

	assign errorCount = errors;
	assign pixelCount = pixels;
	assign frameCount = frames;
	assign redCount   = redPixels;

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		errors++;
	endtask

	//////////////////////////////
	// Sampled mid-cycle away from the active edge
	always @(negedge CLK) begin
		if (!rstN || warmCycles < 2) begin
			// Reset and pipeline fill keep the outputs idle
			if (color !== clockDisplayPkg::colorBlank)
				reportMismatch("color", 32'(clockDisplayPkg::colorBlank), 32'(color));
			if (hSyncOut !== 1'b1)
				reportMismatch("hSyncOut", 32'd1, 32'(hSyncOut));
			if (vSyncOut !== 1'b1)
				reportMismatch("vSyncOut", 32'd1, 32'(vSyncOut));
			warmCycles = rstN ? warmCycles + 1 : 0;
			havePrev = 1'b0;
		end else begin
			pixels++;
			if (havePrev) begin
				wantX = (lastX == 10'd799) ? 10'd0 : lastX + 10'd1;
				wantY = lastY;
				if (lastX == 10'd799)
					wantY = (lastY == 10'd524) ? 10'd0 : lastY + 10'd1;   // 525 lines
				if (pixelX !== wantX)
					reportMismatch("pixelX", 32'(wantX), 32'(pixelX));
				if (pixelY !== wantY)
					reportMismatch("pixelY", 32'(wantY), 32'(pixelY));
			end
			lastX = pixelX;
			lastY = pixelY;
			havePrev = 1'b1;

			wantH = !(pixelX >= 10'd656 && pixelX < 10'd752);   // 96 pixel pulse
			wantV = !(pixelY == 10'd490 || pixelY == 10'd491);
			if (hSyncOut !== wantH)
				reportMismatch("hSyncOut", 32'(wantH), 32'(hSyncOut));
			if (vSyncOut !== wantV)
				reportMismatch("vSyncOut", 32'(wantV), 32'(vSyncOut));

			wantColor = expectedColor(int'(pixelX), int'(pixelY), {year, month, day,
				hours, minutes, seconds, timerHours, timerMinutes, timerSeconds}, alarm);
			if (color !== wantColor)
				reportMismatch("color", 32'(wantColor), 32'(color));
			if (color === clockDisplayPkg::colorAlarm)
				redPixels++;
			if (pixelX == 10'd0 && pixelY == 10'd0)
				frames++;   // Frame start
		end
	end

endmodule

`default_nettype wire

/* sim/tbClockDisplay.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClockDisplay;

	logic        CLK;
	logic        rstN;
	logic [7:0]  year, month, day;
	logic [7:0]  hours, minutes, seconds;
	logic [7:0]  timerHours, timerMinutes, timerSeconds;
	logic        alarm;
	logic [11:0] color;
	logic        hSyncOut, vSyncOut;
	logic [9:0]  pixelX, pixelY;
	logic [31:0] errorCount, pixelCount, frameCount, redCount;
	integer      seed;
	int          tbErrors;

	always #20 CLK = ~CLK;   // 40 ns period

	function automatic logic [3:0] randomDigit();
		int r;
		r = $random(seed);
		return 4'($unsigned(r) % 10);
	endfunction

	task automatic loadNewValues(input logic alarmLevel);
		year         = {randomDigit(), randomDigit()};
		month        = {randomDigit(), randomDigit()};
		day          = {randomDigit(), randomDigit()};
		hours        = {randomDigit(), randomDigit()};
		minutes      = {randomDigit(), randomDigit()};
		seconds      = {randomDigit(), randomDigit()};
		timerHours   = {randomDigit(), randomDigit()};
		timerMinutes = {randomDigit(), randomDigit()};
		timerSeconds = {randomDigit(), randomDigit()};
		alarm        = alarmLevel;
	endtask

	// Returns 2 ns after the edge where vSyncOut shows the level
	task automatic waitVSync(input logic level, output logic reached);
		int cycles;
		int limit;
		cycles = 0;
		limit = int'(clockDisplayPkg::hTotal) * int'(clockDisplayPkg::vTotal) + 100;
		reached = 1'b0;
		while (!reached && cycles < limit) begin
			@(posedge CLK);
			#2;
			reached = (vSyncOut === level);
			cycles++;
		end
		if (!reached) begin
			$display("Timeout: vSyncOut did not become %0b within %0d cycles", level, limit);
			tbErrors++;
		end
	endtask

	clockDisplay i_clockDisplay (
		.CLK(CLK), .rstN(rstN),
		.year(year), .month(month), .day(day),
		.hours(hours), .minutes(minutes), .seconds(seconds),
		.timerHours(timerHours), .timerMinutes(timerMinutes), .timerSeconds(timerSeconds),
		.alarm(alarm), .color(color), .hSyncOut(hSyncOut), .vSyncOut(vSyncOut),
		.pixelX(pixelX), .pixelY(pixelY)
	);

	displayChecker i_displayChecker (
		.CLK(CLK), .rstN(rstN),
		.year(year), .month(month), .day(day),
		.hours(hours), .minutes(minutes), .seconds(seconds),
		.timerHours(timerHours), .timerMinutes(timerMinutes), .timerSeconds(timerSeconds),
		.alarm(alarm), .color(color), .hSyncOut(hSyncOut), .vSyncOut(vSyncOut),
		.pixelX(pixelX), .pixelY(pixelY),
		.errorCount(errorCount), .pixelCount(pixelCount),
		.frameCount(frameCount), .redCount(redCount)
	);

	//////////////////////////////
	// Reset, then new values once per frame in vertical sync
	initial begin
		int   frame;
		logic ok;
		CLK = 1'b0;
		rstN = 1'b0;
		seed = 32'h5027be75;
		tbErrors = 0;
		ok = 1'b1;
		loadNewValues(1'b0);
		repeat (3) @(posedge CLK);
		#2 rstN = 1'b1;

		for (frame = 1; frame <= 4 && ok; frame++) begin
			waitVSync(1'b1, ok);
			if (ok)
				waitVSync(1'b0, ok);
			if (ok)
				loadNewValues(frame % 2 == 1);   // Alarm on in odd frames
		end
		if (ok)
			waitVSync(1'b1, ok);
		if (ok)
			waitVSync(1'b0, ok);   // Last frame fully scanned

		if (frameCount < 5) begin
			$display("Only %0d frames were scanned, expected 5", frameCount);
			tbErrors++;
		end
		if (redCount == 0) begin
			$display("Alarm box was never shown in red");
			tbErrors++;
		end
		$display("Checked %0d pixels, %0d errors", pixelCount, errorCount + tbErrors);
		if (errorCount + tbErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* clockDisplay.f */
+incdir+sim
hdl/clockDisplayPkg.sv
hdl/vgaTiming.sv
hdl/layoutDecoder.sv
hdl/glyphRom.sv
hdl/pixelComposer.sv
hdl/clockDisplay.sv
sim/displayChecker.sv
sim/tbClockDisplay.sv

/* Makefile */
TOP = tbClockDisplay

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f clockDisplay.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
